// ==== Makefile ====
# Verilator build and run for the BBC memory side testbench

VERILATOR ?= verilator
TOP       ?= bbc_mem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
VFLAGS    ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, whatever the simulator exit status was
run: compile
	-$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
src/bbc_mem_pkg.sv
src/rom_loader.sv
src/core_reset_sequencer.sv
src/sdram_address_map.sv
src/bbc_mem_top.sv
verification/bbc_mem_tb.sv

// ==== src/bbc_mem_pkg.sv ====
package bbc_mem_pkg;

	localparam int CPU_ADDR_W   = 16;
	localparam int SDRAM_ADDR_W = 25;
	localparam int BYTE_W       = 8;

	// 6502 side address
	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;

	// byte address into the sdram
	typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;

	typedef logic [BYTE_W-1:0] byte_t;

	// romsel latch: [3:0] page, [7] MOS private RAM enable
	typedef logic [7:0] romsel_t;

	// io controller download index
	typedef logic [7:0] ioctl_index_t;

	// offset bits inside one 16 KB page
	localparam int PAGE_BITS = 14;

	// download targets
	// index 0 carries the OS images, anything else a paged ROM bundle
	localparam sdram_addr_t OS_ROM_BASE    = 25'h80000;
	localparam sdram_addr_t PAGED_ROM_BASE = 25'h68000;

	// reserved for CMOS contents, never written to sdram
	localparam ioctl_index_t CMOS_INDEX = 8'hff;

	// sdram layout
	//   00000-07fff  main RAM
	//   08000-08fff  MOS private RAM
	//   0a000-0bfff  filing system RAM
	//   10000-1ffff  shadow RAM
	//   40000-7ffff  sideways RAM pages
	//   80000-87fff  OS12 / MOS
	//   90000-9ffff  Model B sideways ROMs
	//   a0000-dffff  Master sideways ROMs
	localparam sdram_addr_t FILING_RAM_BASE   = 25'h0A000;
	localparam sdram_addr_t MODEL_B_ROM_BASE  = 25'h90000;
	localparam sdram_addr_t MASTER_ROM_BASE   = 25'hA0000;
	localparam sdram_addr_t SIDEWAYS_RAM_BASE = 25'h40000;

endpackage

// ==== src/bbc_mem_top.sv ====
`timescale 1ns/1ps

module bbc_mem_top #(
	parameter int unsigned REMAP_HOLD_CYCLES = 4095,
	parameter int unsigned AUTOBOOT_CYCLES   = 32000000
) (
	input  logic                       clk_48m,
	input  logic                       reset,
	input  logic                       mem_sync,
	input  logic                       pll_ready,
	input  logic                       sdram_ready,
	input  logic                       osd_reset,
	input  logic                       button_reset,
	input  logic                       model,
	input  logic                       rommap,
	input  logic                       autoboot,
	input  logic                       loader_active,
	input  logic                       ioctl_we,
	input  bbc_mem_pkg::sdram_addr_t   ioctl_addr,
	input  bbc_mem_pkg::ioctl_index_t  ioctl_index,
	input  bbc_mem_pkg::byte_t         ioctl_data,
	input  bbc_mem_pkg::cpu_addr_t     cpu_addr,
	input  bbc_mem_pkg::romsel_t       romsel,
	input  logic                       acc_y,
	input  logic                       shadow_ram,
	input  logic                       shadow_vid,
	input  logic                       phi0,
	input  logic                       cpu_we,
	input  bbc_mem_pkg::byte_t         cpu_dout,
	output bbc_mem_pkg::sdram_addr_t   sdram_addr,
	output logic                       sdram_we,
	output bbc_mem_pkg::byte_t         sdram_din,
	output logic                       core_reset,
	output logic                       autoboot_shift
);

	// registered download write, ahead of the cpu in the address mux
	logic                     loader_we;
	bbc_mem_pkg::sdram_addr_t loader_addr;
	bbc_mem_pkg::byte_t       loader_data;

	rom_loader loader_i (
		.clk_48m       (clk_48m),
		.reset         (reset),
		.mem_sync      (mem_sync),
		.loader_active (loader_active),
		.ioctl_we      (ioctl_we),
		.ioctl_addr    (ioctl_addr),
		.ioctl_index   (ioctl_index),
		.ioctl_data    (ioctl_data),
		.loader_we     (loader_we),
		.loader_addr   (loader_addr),
		.loader_data   (loader_data)
	);

	core_reset_sequencer #(
		.REMAP_HOLD_CYCLES (REMAP_HOLD_CYCLES),
		.AUTOBOOT_CYCLES   (AUTOBOOT_CYCLES)
	) reset_seq_i (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.pll_ready      (pll_ready),
		.sdram_ready    (sdram_ready),
		.osd_reset      (osd_reset),
		.button_reset   (button_reset),
		.loader_active  (loader_active),
		.model          (model),
		.rommap         (rommap),
		.autoboot       (autoboot),
		.core_reset     (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	sdram_address_map addr_map_i (
		.loader_active (loader_active),
		.loader_we     (loader_we),
		.loader_addr   (loader_addr),
		.loader_data   (loader_data),
		.cpu_addr      (cpu_addr),
		.romsel        (romsel),
		.acc_y         (acc_y),
		.shadow_ram    (shadow_ram),
		.shadow_vid    (shadow_vid),
		.phi0          (phi0),
		.cpu_we        (cpu_we),
		.cpu_dout      (cpu_dout),
		.model         (model),
		.rommap        (rommap),
		.sdram_addr    (sdram_addr),
		.sdram_we      (sdram_we),
		.sdram_din     (sdram_din)
	);

endmodule

// ==== src/core_reset_sequencer.sv ====
`timescale 1ns/1ps

module core_reset_sequencer #(
	parameter int unsigned REMAP_HOLD_CYCLES = 4095,
	parameter int unsigned AUTOBOOT_CYCLES   = 32000000
) (
	input  logic clk_48m,
	input  logic reset,
	input  logic mem_sync,
	input  logic pll_ready,
	input  logic sdram_ready,
	input  logic osd_reset,
	input  logic button_reset,
	input  logic loader_active,
	input  logic model,
	input  logic rommap,
	input  logic autoboot,
	output logic core_reset,
	output logic autoboot_shift
);

	localparam int REMAP_W    = $clog2(REMAP_HOLD_CYCLES + 1);
	localparam int AUTOBOOT_W = $clog2(AUTOBOOT_CYCLES + 1);

	logic                  model_q;
	logic                  rommap_q;
	logic                  map_changed;
	logic [REMAP_W-1:0]    remap_count;
	logic                  remap_hold;
	logic                  reset_request;
	logic [AUTOBOOT_W-1:0] autoboot_count;

	// model or rom mapping changed since the previous cycle
	assign map_changed = (model != model_q) || (rommap != rommap_q);
	assign remap_hold  = (remap_count != '0);

	always_ff @(posedge clk_48m) begin
		model_q  <= model;
		rommap_q <= rommap;
		if (reset) begin
			remap_count <= '0;
		end else if (map_changed) begin
			remap_count <= REMAP_W'(REMAP_HOLD_CYCLES);
		end else if (remap_hold) begin
			remap_count <= remap_count - REMAP_W'(1);
		end
	end

	// any single cause keeps the core in reset
	assign reset_request = !pll_ready || !sdram_ready || osd_reset || button_reset ||
		loader_active || remap_hold;

	// core reset may only change on a memory cycle boundary
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else if (mem_sync) begin
			core_reset <= reset_request;
		end
	end

	// shift press timer, armed for the whole of core reset
	always_ff @(posedge clk_48m) begin
		if (reset || core_reset) begin
			autoboot_count <= AUTOBOOT_W'(AUTOBOOT_CYCLES);
		end else if (autoboot_count != '0) begin
			autoboot_count <= autoboot_count - AUTOBOOT_W'(1);
		end
	end

	// the MOS sees shift held and boots from disc
	assign autoboot_shift = autoboot && (autoboot_count != '0);

endmodule

// ==== src/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader (
	input  logic                       clk_48m,
	input  logic                       reset,
	input  logic                       mem_sync,
	input  logic                       loader_active,
	input  logic                       ioctl_we,
	input  bbc_mem_pkg::sdram_addr_t   ioctl_addr,
	input  bbc_mem_pkg::ioctl_index_t  ioctl_index,
	input  bbc_mem_pkg::byte_t         ioctl_data,
	output logic                       loader_we,
	output bbc_mem_pkg::sdram_addr_t   loader_addr,
	output bbc_mem_pkg::byte_t         loader_data
);

	import bbc_mem_pkg::*;

	logic        pending;
	logic        take_write;
	sdram_addr_t region_base;

	// CMOS downloads go elsewhere, never to sdram
	assign take_write = ioctl_we && loader_active && (ioctl_index != CMOS_INDEX);

	// OS images at index 0, everything else into the paged ROM area
	assign region_base = (ioctl_index == '0) ? OS_ROM_BASE : PAGED_ROM_BASE;

	// one slot, drained at each sync
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			pending   <= 1'b0;
			loader_we <= 1'b0;
		end else begin
			if (mem_sync) begin
				loader_we <= pending;
				pending   <= 1'b0;
			end
			// a write landing on the sync cycle waits for the next one
			if (take_write) begin
				pending <= 1'b1;
			end
		end
	end

	// address and data sampled at the sync, not at the write
	always_ff @(posedge clk_48m) begin
		if (mem_sync && pending) begin
			loader_addr <= ioctl_addr + region_base;
			loader_data <= ioctl_data;
		end
	end

endmodule

// ==== src/sdram_address_map.sv ====
`timescale 1ns/1ps

module sdram_address_map (
	input  logic                     loader_active,
	input  logic                     loader_we,
	input  bbc_mem_pkg::sdram_addr_t loader_addr,
	input  bbc_mem_pkg::byte_t       loader_data,
	input  bbc_mem_pkg::cpu_addr_t   cpu_addr,
	input  bbc_mem_pkg::romsel_t     romsel,
	input  logic                     acc_y,
	input  logic                     shadow_ram,
	input  logic                     shadow_vid,
	input  logic                     phi0,
	input  logic                     cpu_we,
	input  bbc_mem_pkg::byte_t       cpu_dout,
	input  logic                     model,
	input  logic                     rommap,
	output bbc_mem_pkg::sdram_addr_t sdram_addr,
	output logic                     sdram_we,
	output bbc_mem_pkg::byte_t       sdram_din
);

	import bbc_mem_pkg::*;

	logic cpu_ram;
	logic mos_rom;
	logic sideways;
	logic mos_ram;
	logic filing_ram;
	logic sideways_ram;
	logic sideways_rom;
	logic master_rom_page;
	logic model_b_rom_page;

	sdram_addr_t page_off;
	sdram_addr_t filing_off;
	sdram_addr_t os_page;
	sdram_addr_t rom_page;
	sdram_addr_t master_bank;
	sdram_addr_t ram_page;

	// region decode of the cpu address
	assign cpu_ram    = !cpu_addr[15];
	assign mos_rom    = (cpu_addr[15:14] == 2'b11);
	assign sideways   = (cpu_addr[15:14] == 2'b10);
	assign mos_ram    = sideways && (cpu_addr[13:12] == 2'b00) && romsel[7];
	assign filing_ram = (cpu_addr[15:13] == 3'b110) && acc_y;

	// pages 4-7 are RAM on both machines
	assign sideways_ram = sideways && (romsel[3:2] == 2'b01);

	// Master keeps ROMs in pages 0-3 and 8-F
	assign master_rom_page = (romsel[3:2] == 2'b00) || romsel[3];
	// Model B, low mapping puts the four ROMs at 0-3, high at C-F
	assign model_b_rom_page = rommap ? (romsel[3:2] == 2'b00) : (romsel[3:2] == 2'b11);

	assign sideways_rom = sideways && (model ? master_rom_page : model_b_rom_page);

	assign page_off    = sdram_addr_t'(cpu_addr[PAGE_BITS-1:0]);
	assign filing_off  = sdram_addr_t'(cpu_addr[12:0]);
	assign os_page     = sdram_addr_t'(model) << PAGE_BITS;
	assign rom_page    = sdram_addr_t'(romsel[1:0]) << PAGE_BITS;
	// 64 KB per group of four Master ROM pages
	assign master_bank = sdram_addr_t'(romsel[3:2]) << (PAGE_BITS + 2);
	assign ram_page    = sdram_addr_t'(romsel[3:0]) << PAGE_BITS;

	always_comb begin
		if (loader_active) begin
			sdram_addr = loader_addr;
		end else if (!phi0) begin
			// video fetch
			sdram_addr = sdram_addr_t'({shadow_vid, cpu_addr});
		end else if (cpu_ram || mos_ram) begin
			sdram_addr = sdram_addr_t'({shadow_ram, cpu_addr});
		end else if (filing_ram) begin
			sdram_addr = FILING_RAM_BASE + filing_off;
		end else if (mos_rom) begin
			sdram_addr = OS_ROM_BASE + os_page + page_off;
		end else if (sideways_rom && !model) begin
			sdram_addr = MODEL_B_ROM_BASE + rom_page + page_off;
		end else if (sideways_rom) begin
			sdram_addr = MASTER_ROM_BASE + master_bank + rom_page + page_off;
		end else begin
			sdram_addr = SIDEWAYS_RAM_BASE + ram_page + page_off;
		end
	end

	// ROM regions are read only to the cpu
	assign sdram_we = loader_active ? loader_we :
		(cpu_we && (cpu_ram || mos_ram || filing_ram || sideways_ram));

	assign sdram_din = loader_active ? loader_data : cpu_dout;

endmodule

// ==== verification/bbc_mem_tb.sv ====
`timescale 1ns/1ps

module bbc_mem_tb;

	import bbc_mem_pkg::*;

	localparam int CLK_PERIOD        = 20;
	localparam int REMAP_HOLD_CYCLES = 64;
	localparam int AUTOBOOT_CYCLES   = 300;
	localparam int N_ACCESSES        = 2000;
	localparam int N_LOADS           = 60;
	// cycles spent outside the remap and autoboot waits, with margin
	localparam int TEST_CYCLES       = N_ACCESSES + N_LOADS * 16 + 600;
	localparam int WATCHDOG_CYCLES   = (TEST_CYCLES + AUTOBOOT_CYCLES + REMAP_HOLD_CYCLES) * 2;
	localparam logic [31:0] LFSR_SEED = 32'h261a;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic         clk_48m = 1'b0;
	logic         reset;
	logic         mem_sync;
	logic         pll_ready;
	logic         sdram_ready;
	logic         osd_reset;
	logic         button_reset;
	logic         model;
	logic         rommap;
	logic         autoboot;
	logic         loader_active;
	logic         ioctl_we;
	sdram_addr_t  ioctl_addr;
	ioctl_index_t ioctl_index;
	byte_t        ioctl_data;
	cpu_addr_t    cpu_addr;
	romsel_t      romsel;
	logic         acc_y;
	logic         shadow_ram;
	logic         shadow_vid;
	logic         phi0;
	logic         cpu_we;
	byte_t        cpu_dout;
	sdram_addr_t  sdram_addr;
	logic         sdram_we;
	byte_t        sdram_din;
	logic         core_reset;
	logic         autoboot_shift;

	logic [31:0] lfsr_state;
	logic [1:0]  sync_phase;
	int          cycle_count;

	// reference model state for reset and autoboot
	logic m_model_q;
	logic m_rommap_q;
	logic m_core_reset;
	int   m_remap_count;
	int   m_boot_count;

	bbc_mem_top #(
		.REMAP_HOLD_CYCLES (REMAP_HOLD_CYCLES),
		.AUTOBOOT_CYCLES   (AUTOBOOT_CYCLES)
	) dut_i (
		.clk_48m        (clk_48m),
		.reset          (reset),
		.mem_sync       (mem_sync),
		.pll_ready      (pll_ready),
		.sdram_ready    (sdram_ready),
		.osd_reset      (osd_reset),
		.button_reset   (button_reset),
		.model          (model),
		.rommap         (rommap),
		.autoboot       (autoboot),
		.loader_active  (loader_active),
		.ioctl_we       (ioctl_we),
		.ioctl_addr     (ioctl_addr),
		.ioctl_index    (ioctl_index),
		.ioctl_data     (ioctl_data),
		.cpu_addr       (cpu_addr),
		.romsel         (romsel),
		.acc_y          (acc_y),
		.shadow_ram     (shadow_ram),
		.shadow_vid     (shadow_vid),
		.phi0           (phi0),
		.cpu_we         (cpu_we),
		.cpu_dout       (cpu_dout),
		.sdram_addr     (sdram_addr),
		.sdram_we       (sdram_we),
		.sdram_din      (sdram_din),
		.core_reset     (core_reset),
		.autoboot_shift (autoboot_shift)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk_48m = ~clk_48m;
	end

	// one sync strobe every fourth cycle
	always @(negedge clk_48m) begin
		mem_sync   = (sync_phase == 2'd2);
		sync_phase = sync_phase + 2'd1;
	end

	always @(posedge clk_48m) begin
		cycle_count = cycle_count + 1;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic rand_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// memory map as seen from the cpu
	function automatic sdram_addr_t expect_addr(input cpu_addr_t a, input romsel_t r,
			input logic acc_y_v, input logic shadow_ram_v, input logic shadow_vid_v,
			input logic phi0_v, input logic model_v, input logic rommap_v);
		logic rom_hit;
		if (!phi0_v) begin
			return {8'h00, shadow_vid_v, a};
		end
		if (!a[15] || (a[15:14] == 2'b10 && a[13:12] == 2'b00 && r[7])) begin
			return {8'h00, shadow_ram_v, a};
		end
		if (a[15:13] == 3'b110 && acc_y_v) begin
			return FILING_RAM_BASE + {12'h000, a[12:0]};
		end
		if (a[15:14] == 2'b11) begin
			return OS_ROM_BASE + {10'h000, model_v, a[13:0]};
		end
		if (model_v) begin
			rom_hit = (r[3:2] == 2'b00) || r[3];
		end else begin
			rom_hit = rommap_v ? (r[3:2] == 2'b00) : (r[3:2] == 2'b11);
		end
		if (rom_hit && !model_v) begin
			return MODEL_B_ROM_BASE + {9'h000, r[1:0], a[13:0]};
		end
		if (rom_hit) begin
			return MASTER_ROM_BASE + {7'h00, r[3:0], a[13:0]};
		end
		return SIDEWAYS_RAM_BASE + {7'h00, r[3:0], a[13:0]};
	endfunction

	function automatic logic expect_we(input cpu_addr_t a, input romsel_t r,
			input logic acc_y_v, input logic we_v);
		logic writable;
		writable = !a[15] ||
			(a[15:14] == 2'b10 && a[13:12] == 2'b00 && r[7]) ||
			(a[15:13] == 3'b110 && acc_y_v) ||
			(a[15:14] == 2'b10 && r[3:2] == 2'b01);
		return we_v && writable;
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_failure("sdram address mismatch");
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_failure("data byte mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			stop_on_failure("control bit mismatch");
		end
	endtask

	// reset sources, remap hold and shift timer, cycle by cycle
	always @(posedge clk_48m) begin
		m_model_q  <= model;
		m_rommap_q <= rommap;
		if (reset) begin
			m_remap_count <= 0;
			m_core_reset  <= 1'b1;
			m_boot_count  <= AUTOBOOT_CYCLES;
		end else begin
			if (model != m_model_q || rommap != m_rommap_q) begin
				m_remap_count <= REMAP_HOLD_CYCLES;
			end else if (m_remap_count != 0) begin
				m_remap_count <= m_remap_count - 1;
			end
			if (mem_sync) begin
				m_core_reset <= !pll_ready || !sdram_ready || osd_reset || button_reset ||
					loader_active || (m_remap_count != 0);
			end
			if (m_core_reset) begin
				m_boot_count <= AUTOBOOT_CYCLES;
			end else if (m_boot_count != 0) begin
				m_boot_count <= m_boot_count - 1;
			end
		end
	end

	always begin
		@(negedge clk_48m);
		#5;
		if (!reset) begin
			check_bit("core_reset", core_reset, m_core_reset);
			check_bit("autoboot_shift", autoboot_shift, autoboot && (m_boot_count != 0));
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles without the tests finishing", cycle_count);
		$display(">>> FAIL");
		$fatal(1);
	end

	task automatic wait_sync();
		do begin
			@(posedge clk_48m);
		end while (!mem_sync);
	endtask

	task automatic wait_core_reset(input logic level, input int limit);
		int waited;
		waited = 0;
		while (core_reset !== level) begin
			@(negedge clk_48m);
			waited++;
			if (waited > limit) begin
				stop_on_failure($sformatf("core_reset did not reach %0b within %0d cycles",
					level, limit));
			end
		end
	endtask

	task automatic drive_random_cpu();
		cpu_addr   = cpu_addr_t'(rand_bits(16));
		romsel     = romsel_t'(rand_bits(8));
		acc_y      = rand_bit();
		shadow_ram = rand_bit();
		shadow_vid = rand_bit();
		phi0       = rand_bit();
		cpu_we     = rand_bit();
		cpu_dout   = byte_t'(rand_bits(8));
		model      = rand_bit();
		rommap     = rand_bit();
	endtask

	task automatic run_cpu_accesses();
		int n;
		for (n = 0; n < N_ACCESSES; n++) begin
			@(negedge clk_48m);
			drive_random_cpu();
			#5;
			check_addr("sdram_addr", sdram_addr, expect_addr(cpu_addr, romsel, acc_y,
				shadow_ram, shadow_vid, phi0, model, rommap));
			check_bit("sdram_we", sdram_we, expect_we(cpu_addr, romsel, acc_y, cpu_we));
			check_byte("sdram_din", sdram_din, cpu_dout);
		end
	endtask

	task automatic run_downloads();
		int          n;
		logic        exp_we;
		sdram_addr_t exp_addr;
		for (n = 0; n < N_LOADS; n++) begin
			wait_sync();
			@(negedge clk_48m);
			drive_random_cpu();
			// a cpu write the loader has to win over
			cpu_we        = 1'b1;
			loader_active = 1'b1;
			ioctl_we      = 1'b1;
			ioctl_addr    = sdram_addr_t'(rand_bits(20));
			ioctl_data    = byte_t'(rand_bits(8));
			case (2'(rand_bits(2)))
				2'd1:    ioctl_index = 8'h05;
				2'd2:    ioctl_index = CMOS_INDEX;
				default: ioctl_index = 8'h00;
			endcase
			exp_we   = (ioctl_index != CMOS_INDEX);
			exp_addr = ioctl_addr + ((ioctl_index == 8'h00) ? OS_ROM_BASE : PAGED_ROM_BASE);
			@(negedge clk_48m);
			ioctl_we = 1'b0;
			wait_sync();
			@(negedge clk_48m);
			#5;
			check_bit("loader_we", dut_i.loader_we, exp_we);
			check_bit("sdram_we", sdram_we, exp_we);
			if (exp_we) begin
				check_addr("sdram_addr", sdram_addr, exp_addr);
				check_byte("sdram_din", sdram_din, ioctl_data);
			end
			// one sync period long
			wait_sync();
			@(negedge clk_48m);
			#5;
			check_bit("sdram_we", sdram_we, 1'b0);
		end
	endtask

	task automatic drive_source(input int index, input logic active);
		case (index)
			0:       pll_ready     = !active;
			1:       sdram_ready   = !active;
			2:       osd_reset     = active;
			3:       button_reset  = active;
			default: loader_active = active;
		endcase
	endtask

	task automatic run_reset_sources();
		int src;
		@(negedge clk_48m);
		loader_active = 1'b0;
		cpu_we        = 1'b0;
		wait_core_reset(1'b0, REMAP_HOLD_CYCLES + 16);
		for (src = 0; src < 5; src++) begin
			@(negedge clk_48m);
			drive_source(src, 1'b1);
			wait_sync();
			@(negedge clk_48m);
			check_bit("core_reset", core_reset, 1'b1);
			drive_source(src, 1'b0);
			wait_sync();
			@(negedge clk_48m);
			check_bit("core_reset", core_reset, 1'b0);
		end
	endtask

	task automatic run_remap_hold();
		int k;
		int start;
		for (k = 0; k < 2; k++) begin
			@(negedge clk_48m);
			wait_core_reset(1'b0, 16);
			if (k == 0) begin
				model = !model;
			end else begin
				rommap = !rommap;
			end
			start = cycle_count;
			wait_core_reset(1'b1, 12);
			wait_core_reset(1'b0, REMAP_HOLD_CYCLES + 16);
			if (cycle_count - start < REMAP_HOLD_CYCLES) begin
				stop_on_failure($sformatf("core reset released %0d cycles after a remap",
					cycle_count - start));
			end
		end
	endtask

	task automatic measure_autoboot(input logic enable, output int high_cycles);
		@(negedge clk_48m);
		autoboot     = enable;
		button_reset = 1'b1;
		wait_core_reset(1'b1, 12);
		button_reset = 1'b0;
		wait_core_reset(1'b0, 12);
		high_cycles = 0;
		repeat (AUTOBOOT_CYCLES + 20) begin
			if (autoboot_shift) begin
				high_cycles++;
			end
			@(negedge clk_48m);
		end
	endtask

	initial begin
		int shift_cycles;
		lfsr_state    = LFSR_SEED;
		cycle_count   = 0;
		sync_phase    = 2'd0;
		mem_sync      = 1'b0;
		reset         = 1'b1;
		pll_ready     = 1'b1;
		sdram_ready   = 1'b1;
		osd_reset     = 1'b0;
		button_reset  = 1'b0;
		model         = 1'b0;
		rommap        = 1'b0;
		autoboot      = 1'b0;
		loader_active = 1'b0;
		ioctl_we      = 1'b0;
		ioctl_addr    = '0;
		ioctl_index   = '0;
		ioctl_data    = '0;
		cpu_addr      = '0;
		romsel        = '0;
		acc_y         = 1'b0;
		shadow_ram    = 1'b0;
		shadow_vid    = 1'b0;
		phi0          = 1'b1;
		cpu_we        = 1'b0;
		cpu_dout      = '0;
		repeat (3) @(negedge clk_48m);
		reset = 1'b0;

		run_cpu_accesses();
		run_downloads();
		run_reset_sources();
		run_remap_hold();

		measure_autoboot(1'b1, shift_cycles);
		if (shift_cycles != AUTOBOOT_CYCLES) begin
			stop_on_failure($sformatf("autoboot shift held for %0d cycles instead of %0d",
				shift_cycles, AUTOBOOT_CYCLES));
		end
		measure_autoboot(1'b0, shift_cycles);
		if (shift_cycles != 0) begin
			stop_on_failure("autoboot shift went high with autoboot off");
		end

		$display(">>> PASS");
		$finish;
	end

endmodule
